// ==== rtl/scoreboard_pkg.sv ====
package scoreboard_pkg;

    localparam int NUM_FU = 4;

    typedef logic [1:0]        fu_id_t;
    typedef logic [NUM_FU-1:0] fu_vec_t;
    typedef logic [4:0]        reg_addr_t;
    typedef logic [4:0]        fu_op_t;

    // Unit ids in dispatch and write-back priority order
    localparam fu_id_t FU_ALU = 2'd0;
    localparam fu_id_t FU_MEM = 2'd1;
    localparam fu_id_t FU_MUL = 2'd2;
    localparam fu_id_t FU_DIV = 2'd3;

    localparam logic [6:0] OPC_R     = 7'b0110011;
    localparam logic [6:0] OPC_I     = 7'b0010011;
    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;
    localparam logic [6:0] OPC_LUI   = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC = 7'b0010111;

    // ALU register forms
    localparam fu_op_t ALU_ADD   = 5'd0;
    localparam fu_op_t ALU_SUB   = 5'd1;
    localparam fu_op_t ALU_AND   = 5'd2;
    localparam fu_op_t ALU_OR    = 5'd3;
    localparam fu_op_t ALU_XOR   = 5'd4;
    localparam fu_op_t ALU_SLL   = 5'd5;
    localparam fu_op_t ALU_SRL   = 5'd6;
    localparam fu_op_t ALU_SLT   = 5'd7;
    localparam fu_op_t ALU_SLTU  = 5'd8;
    localparam fu_op_t ALU_SRA   = 5'd9;

    // Bit 4 marks an immediate operand
    localparam fu_op_t ALU_ADDI  = 5'd16;
    localparam fu_op_t ALU_ANDI  = 5'd18;
    localparam fu_op_t ALU_ORI   = 5'd19;
    localparam fu_op_t ALU_XORI  = 5'd20;
    localparam fu_op_t ALU_SLLI  = 5'd21;
    localparam fu_op_t ALU_SRLI  = 5'd22;
    localparam fu_op_t ALU_SLTI  = 5'd23;
    localparam fu_op_t ALU_SLTIU = 5'd24;
    localparam fu_op_t ALU_SRAI  = 5'd25;
    localparam fu_op_t ALU_LUI   = 5'd26;
    localparam fu_op_t ALU_AUIPC = 5'd27;

    // MEM bit 3 is unsigned, bits 2:1 are size and bit 0 is write
    localparam fu_op_t MEM_LB    = 5'b00000;
    localparam fu_op_t MEM_LH    = 5'b00010;
    localparam fu_op_t MEM_LW    = 5'b00100;
    localparam fu_op_t MEM_LBU   = 5'b01000;
    localparam fu_op_t MEM_LHU   = 5'b01010;
    localparam fu_op_t MEM_SB    = 5'b00001;
    localparam fu_op_t MEM_SH    = 5'b00011;
    localparam fu_op_t MEM_SW    = 5'b00101;

    localparam fu_op_t MUL_MUL    = 5'd0;
    localparam fu_op_t MUL_MULH   = 5'd1;
    localparam fu_op_t MUL_MULHSU = 5'd2;
    localparam fu_op_t MUL_MULHU  = 5'd3;

    localparam fu_op_t DIV_DIV   = 5'd0;
    localparam fu_op_t DIV_DIVU  = 5'd1;
    localparam fu_op_t DIV_REM   = 5'd2;
    localparam fu_op_t DIV_REMU  = 5'd3;

    typedef struct packed {
        logic      legal;
        fu_id_t    fu;
        fu_op_t    op;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
    } decoded_t;

    typedef struct packed {
        logic      busy;
        fu_op_t    op;
        reg_addr_t dst;
        reg_addr_t src1;
        reg_addr_t src2;
        fu_id_t    prod1;
        logic      pend1;
        fu_id_t    prod2;
        logic      pend2;
        logic      rdy1;
        logic      rdy2;
        logic      dispatched;
        logic      done;
    } fu_status_t;

    typedef struct packed {
        fu_id_t    fu;
        fu_op_t    op;
        reg_addr_t rs1;
        reg_addr_t rs2;
    } dispatch_t;

    typedef struct packed {
        fu_id_t    fu;
        reg_addr_t rd;
    } wb_t;

endpackage

// ==== rtl/inst_decoder.sv ====
module inst_decoder (
    input  logic [31:0]              inst,
    output scoreboard_pkg::decoded_t dec
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       alt;
    logic       use_rd;
    logic       use_rs1;
    logic       use_rs2;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    // SUB and SRA/SRAI encoding
    assign alt    = funct7 == 7'h20;

    always_comb begin
        dec.legal = 1'b0;
        dec.fu    = scoreboard_pkg::FU_ALU;
        dec.op    = scoreboard_pkg::ALU_ADD;
        use_rd    = 1'b0;
        use_rs1   = 1'b0;
        use_rs2   = 1'b0;

        case (opcode)
            scoreboard_pkg::OPC_R: begin
                use_rd  = 1'b1;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                if (funct7 == 7'h01) begin
                    // RV32M where funct3[2] selects divide
                    dec.legal = 1'b1;
                    dec.fu    = funct3[2] ? scoreboard_pkg::FU_DIV : scoreboard_pkg::FU_MUL;
                    case (funct3)
                        3'h0:    dec.op = scoreboard_pkg::MUL_MUL;
                        3'h1:    dec.op = scoreboard_pkg::MUL_MULH;
                        3'h2:    dec.op = scoreboard_pkg::MUL_MULHSU;
                        3'h3:    dec.op = scoreboard_pkg::MUL_MULHU;
                        3'h4:    dec.op = scoreboard_pkg::DIV_DIV;
                        3'h5:    dec.op = scoreboard_pkg::DIV_DIVU;
                        3'h6:    dec.op = scoreboard_pkg::DIV_REM;
                        default: dec.op = scoreboard_pkg::DIV_REMU;
                    endcase
                end else begin
                    dec.legal = (funct7 == 7'h00) || (alt && (funct3 == 3'h0 || funct3 == 3'h5));
                    case (funct3)
                        3'h0:    dec.op = alt ? scoreboard_pkg::ALU_SUB : scoreboard_pkg::ALU_ADD;
                        3'h1:    dec.op = scoreboard_pkg::ALU_SLL;
                        3'h2:    dec.op = scoreboard_pkg::ALU_SLT;
                        3'h3:    dec.op = scoreboard_pkg::ALU_SLTU;
                        3'h4:    dec.op = scoreboard_pkg::ALU_XOR;
                        3'h5:    dec.op = alt ? scoreboard_pkg::ALU_SRA : scoreboard_pkg::ALU_SRL;
                        3'h6:    dec.op = scoreboard_pkg::ALU_OR;
                        default: dec.op = scoreboard_pkg::ALU_AND;
                    endcase
                end
            end
            scoreboard_pkg::OPC_I: begin
                use_rd  = 1'b1;
                use_rs1 = 1'b1;
                // Shifts carry a funct7 field
                if (funct3 == 3'h1) begin
                    dec.legal = funct7 == 7'h00;
                end else if (funct3 == 3'h5) begin
                    dec.legal = (funct7 == 7'h00) || alt;
                end else begin
                    dec.legal = 1'b1;
                end
                case (funct3)
                    3'h0:    dec.op = scoreboard_pkg::ALU_ADDI;
                    3'h1:    dec.op = scoreboard_pkg::ALU_SLLI;
                    3'h2:    dec.op = scoreboard_pkg::ALU_SLTI;
                    3'h3:    dec.op = scoreboard_pkg::ALU_SLTIU;
                    3'h4:    dec.op = scoreboard_pkg::ALU_XORI;
                    3'h5:    dec.op = alt ? scoreboard_pkg::ALU_SRAI : scoreboard_pkg::ALU_SRLI;
                    3'h6:    dec.op = scoreboard_pkg::ALU_ORI;
                    default: dec.op = scoreboard_pkg::ALU_ANDI;
                endcase
            end
            scoreboard_pkg::OPC_LOAD: begin
                use_rd    = 1'b1;
                use_rs1   = 1'b1;
                dec.fu    = scoreboard_pkg::FU_MEM;
                dec.legal = 1'b1;
                case (funct3)
                    3'h0:    dec.op = scoreboard_pkg::MEM_LB;
                    3'h1:    dec.op = scoreboard_pkg::MEM_LH;
                    3'h2:    dec.op = scoreboard_pkg::MEM_LW;
                    3'h4:    dec.op = scoreboard_pkg::MEM_LBU;
                    3'h5:    dec.op = scoreboard_pkg::MEM_LHU;
                    default: dec.legal = 1'b0;
                endcase
            end
            scoreboard_pkg::OPC_STORE: begin
                use_rs1   = 1'b1;
                use_rs2   = 1'b1;
                dec.fu    = scoreboard_pkg::FU_MEM;
                dec.legal = 1'b1;
                case (funct3)
                    3'h0:    dec.op = scoreboard_pkg::MEM_SB;
                    3'h1:    dec.op = scoreboard_pkg::MEM_SH;
                    3'h2:    dec.op = scoreboard_pkg::MEM_SW;
                    default: dec.legal = 1'b0;
                endcase
            end
            scoreboard_pkg::OPC_LUI: begin
                use_rd    = 1'b1;
                dec.legal = 1'b1;
                dec.op    = scoreboard_pkg::ALU_LUI;
            end
            scoreboard_pkg::OPC_AUIPC: begin
                use_rd    = 1'b1;
                dec.legal = 1'b1;
                dec.op    = scoreboard_pkg::ALU_AUIPC;
            end
            default: dec.legal = 1'b0;
        endcase

        // Unused register fields read as x0
        dec.rd  = use_rd ? inst[11:7] : '0;
        dec.rs1 = use_rs1 ? inst[19:15] : '0;
        dec.rs2 = use_rs2 ? inst[24:20] : '0;
    end

endmodule

// ==== rtl/war_check.sv ====
module war_check (
    input  scoreboard_pkg::fu_status_t status [scoreboard_pkg::NUM_FU],
    output scoreboard_pkg::fu_vec_t    war_clear
);

    logic hit1;
    logic hit2;

    always_comb begin
        war_clear = '1;
        hit1      = 1'b0;
        hit2      = 1'b0;
        for (int i = 0; i < scoreboard_pkg::NUM_FU; i++) begin
            for (int j = 0; j < scoreboard_pkg::NUM_FU; j++) begin
                // An older reader still holding the old value of our destination
                hit1 = status[j].rdy1 && status[j].src1 == status[i].dst;
                hit2 = status[j].rdy2 && status[j].src2 == status[i].dst;
                if (j != i && status[j].busy && !status[j].dispatched &&
                    status[i].dst != '0 && (hit1 || hit2)) begin
                    war_clear[i] = 1'b0;
                end
            end
        end
    end

endmodule

// ==== rtl/fu_priority_select.sv ====
module fu_priority_select #(
    parameter type payload_t = logic
) (
    input  scoreboard_pkg::fu_vec_t req,
    input  payload_t                payload [scoreboard_pkg::NUM_FU],
    output payload_t                sel,
    output logic                    sel_valid
);

    assign sel_valid = |req;

    // Walk from the top so the lowest requesting unit wins
    always_comb begin
        sel = '0;
        for (int i = scoreboard_pkg::NUM_FU - 1; i >= 0; i--) begin
            if (req[i]) begin
                sel = payload[i];
            end
        end
    end

endmodule

// ==== rtl/scoreboard_ctrl.sv ====
module scoreboard_ctrl (
    input  logic                       clk,
    input  logic                       rst,
    input  scoreboard_pkg::decoded_t   dec,
    input  logic                       issue_valid,
    output logic                       issue_ready,
    output scoreboard_pkg::fu_status_t status [scoreboard_pkg::NUM_FU],
    input  scoreboard_pkg::fu_vec_t    war_clear,
    output scoreboard_pkg::fu_vec_t    disp_req,
    output scoreboard_pkg::dispatch_t  disp_pkt [scoreboard_pkg::NUM_FU],
    input  logic                       dispatch_fire,
    input  scoreboard_pkg::dispatch_t  dispatch_sel,
    output scoreboard_pkg::fu_vec_t    wb_req,
    output scoreboard_pkg::wb_t        wb_pkt [scoreboard_pkg::NUM_FU],
    input  logic                       wb_fire,
    input  scoreboard_pkg::wb_t        wb_sel,
    input  scoreboard_pkg::fu_vec_t    fu_done
);

    logic                    waw;
    logic                    issue_fire;
    logic                    src1_ready;
    logic                    src2_ready;
    // Register result table
    logic [31:0]             rrs_valid;
    scoreboard_pkg::fu_id_t  rrs_fu [32];
    scoreboard_pkg::fu_vec_t disp_raw;
    scoreboard_pkg::fu_vec_t wb_raw;
    logic                    disp_lock;
    scoreboard_pkg::fu_id_t  disp_lock_fu;
    logic                    wb_lock;
    scoreboard_pkg::fu_id_t  wb_lock_fu;

    always_comb begin
        waw = 1'b0;
        for (int i = 0; i < scoreboard_pkg::NUM_FU; i++) begin
            if (status[i].busy && status[i].dst == dec.rd && dec.rd != '0) begin
                waw = 1'b1;
            end
        end
    end

    // Illegal words are taken and dropped
    assign issue_ready = !dec.legal || (!status[dec.fu].busy && !waw);
    assign issue_fire  = issue_valid && issue_ready && dec.legal;

    // Producer written back this cycle counts as ready
    assign src1_ready = !rrs_valid[dec.rs1] || (wb_fire && rrs_fu[dec.rs1] == wb_sel.fu);
    assign src2_ready = !rrs_valid[dec.rs2] || (wb_fire && rrs_fu[dec.rs2] == wb_sel.fu);

    always_comb begin
        for (int i = 0; i < scoreboard_pkg::NUM_FU; i++) begin
            disp_raw[i] = status[i].busy && !status[i].dispatched &&
                          status[i].rdy1 && status[i].rdy2;
            wb_raw[i]   = status[i].done && war_clear[i];
            disp_pkt[i] = '{fu:  scoreboard_pkg::fu_id_t'(i),
                            op:  status[i].op,
                            rs1: status[i].src1,
                            rs2: status[i].src2};
            wb_pkt[i]   = '{fu: scoreboard_pkg::fu_id_t'(i), rd: status[i].dst};
        end
    end

    // A stalled grant keeps its unit until it transfers
    assign disp_req = disp_lock ? disp_raw & (scoreboard_pkg::fu_vec_t'(1) << disp_lock_fu)
                                : disp_raw;
    assign wb_req   = wb_lock ? wb_raw & (scoreboard_pkg::fu_vec_t'(1) << wb_lock_fu)
                              : wb_raw;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < scoreboard_pkg::NUM_FU; i++) begin
                status[i] <= '0;
            end
            rrs_valid    <= '0;
            disp_lock    <= 1'b0;
            disp_lock_fu <= scoreboard_pkg::FU_ALU;
            wb_lock      <= 1'b0;
            wb_lock_fu   <= scoreboard_pkg::FU_ALU;
        end else begin
            disp_lock    <= |disp_req && !dispatch_fire;
            disp_lock_fu <= dispatch_sel.fu;
            wb_lock      <= |wb_req && !wb_fire;
            wb_lock_fu   <= wb_sel.fu;

            for (int i = 0; i < scoreboard_pkg::NUM_FU; i++) begin
                if (fu_done[i]) begin
                    status[i].done <= 1'b1;
                end
                // Wake up readers of the unit being written back
                if (wb_fire && status[i].pend1 && status[i].prod1 == wb_sel.fu) begin
                    status[i].rdy1  <= 1'b1;
                    status[i].pend1 <= 1'b0;
                end
                if (wb_fire && status[i].pend2 && status[i].prod2 == wb_sel.fu) begin
                    status[i].rdy2  <= 1'b1;
                    status[i].pend2 <= 1'b0;
                end
            end

            if (dispatch_fire) begin
                status[dispatch_sel.fu].dispatched <= 1'b1;
            end

            if (issue_fire) begin
                status[dec.fu] <= '{busy:       1'b1,
                                    op:         dec.op,
                                    dst:        dec.rd,
                                    src1:       dec.rs1,
                                    src2:       dec.rs2,
                                    prod1:      rrs_fu[dec.rs1],
                                    pend1:      !src1_ready,
                                    prod2:      rrs_fu[dec.rs2],
                                    pend2:      !src2_ready,
                                    rdy1:       src1_ready,
                                    rdy2:       src2_ready,
                                    dispatched: 1'b0,
                                    done:       1'b0};
                if (dec.rd != '0) begin
                    rrs_valid[dec.rd] <= 1'b1;
                end
            end

            // WAW stall keeps this apart from the issue entry and register
            if (wb_fire) begin
                status[wb_sel.fu]    <= '0;
                rrs_valid[wb_sel.rd] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue_fire && dec.rd != '0) begin
            rrs_fu[dec.rd] <= dec.fu;
        end
    end

endmodule

// ==== rtl/scoreboard_top.sv ====
module scoreboard_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [31:0]               inst,
    input  logic                      issue_valid,
    output logic                      issue_ready,
    output scoreboard_pkg::dispatch_t dispatch,
    output logic                      dispatch_valid,
    input  logic                      dispatch_ready,
    input  scoreboard_pkg::fu_vec_t   fu_done,
    output scoreboard_pkg::wb_t       wb,
    output logic                      wb_valid,
    input  logic                      wb_ready
);

    scoreboard_pkg::decoded_t   dec;
    scoreboard_pkg::fu_status_t status [scoreboard_pkg::NUM_FU];
    scoreboard_pkg::fu_vec_t    war_clear;
    scoreboard_pkg::fu_vec_t    disp_req;
    scoreboard_pkg::dispatch_t  disp_pkt [scoreboard_pkg::NUM_FU];
    scoreboard_pkg::fu_vec_t    wb_req;
    scoreboard_pkg::wb_t        wb_pkt [scoreboard_pkg::NUM_FU];
    logic                       dispatch_fire;
    logic                       wb_fire;

    assign dispatch_fire = dispatch_valid && dispatch_ready;
    assign wb_fire       = wb_valid && wb_ready;

    inst_decoder inst_decoder_i (
        .inst (inst),
        .dec  (dec)
    );

    war_check war_check_i (
        .status    (status),
        .war_clear (war_clear)
    );

    scoreboard_ctrl scoreboard_ctrl_i (
        .clk           (clk),
        .rst           (rst),
        .dec           (dec),
        .issue_valid   (issue_valid),
        .issue_ready   (issue_ready),
        .status        (status),
        .war_clear     (war_clear),
        .disp_req      (disp_req),
        .disp_pkt      (disp_pkt),
        .dispatch_fire (dispatch_fire),
        .dispatch_sel  (dispatch),
        .wb_req        (wb_req),
        .wb_pkt        (wb_pkt),
        .wb_fire       (wb_fire),
        .wb_sel        (wb),
        .fu_done       (fu_done)
    );

    // Operand read port
    fu_priority_select #(
        .payload_t (scoreboard_pkg::dispatch_t)
    ) dispatch_select (
        .req       (disp_req),
        .payload   (disp_pkt),
        .sel       (dispatch),
        .sel_valid (dispatch_valid)
    );

    // Register file write port
    fu_priority_select #(
        .payload_t (scoreboard_pkg::wb_t)
    ) wb_select (
        .req       (wb_req),
        .payload   (wb_pkt),
        .sel       (wb),
        .sel_valid (wb_valid)
    );

endmodule

// ==== verification/scoreboard_tb.sv ====
module scoreboard_tb;

    logic                      clk;
    logic                      rst;
    logic [31:0]               inst;
    logic                      issue_valid;
    logic                      issue_ready;
    scoreboard_pkg::dispatch_t dispatch;
    logic                      dispatch_valid;
    logic                      dispatch_ready;
    scoreboard_pkg::fu_vec_t   fu_done;
    scoreboard_pkg::wb_t       wb;
    logic                      wb_valid;
    logic                      wb_ready;

    int          test_errors;
    int          total_errors;
    int          tests_run;
    logic [31:0] rnd_state;
    // Expected producer records per register
    logic        pending [32];

    scoreboard_top scoreboard_top_i (
        .clk            (clk),
        .rst            (rst),
        .inst           (inst),
        .issue_valid    (issue_valid),
        .issue_ready    (issue_ready),
        .dispatch       (dispatch),
        .dispatch_valid (dispatch_valid),
        .dispatch_ready (dispatch_ready),
        .fu_done        (fu_done),
        .wb             (wb),
        .wb_valid       (wb_valid),
        .wb_ready       (wb_ready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] lw_word(input logic [4:0] rd, input logic [4:0] rs1);
        return {12'h010, rs1, 3'h2, rd, 7'b0000011};
    endfunction

    task automatic check(input string name, input int got, input int exp);
        assert (got == exp) else begin
            $display("** Error %0t: %s got %0d expected %0d", $time, name, got, exp);
            test_errors++;
        end
    endtask

    task automatic timeout(input string what);
        $display("Timeout at %0t while waiting for %s", $time, what);
        $display("RESULT: FAIL");
        $finish;
    endtask

    task automatic issue_word(input logic [31:0] word, input logic [4:0] rd);
        int n;
        n = 0;
        @(posedge clk);
        inst        <= word;
        issue_valid <= 1'b1;
        @(negedge clk);
        while (!issue_ready) begin
            n++;
            if (n > 50) timeout("issue_ready");
            @(negedge clk);
        end
        @(posedge clk);
        issue_valid <= 1'b0;
        if (rd != 5'd0) pending[rd] = 1'b1;
    endtask

    task automatic expect_dispatch(input int fu, input int op, input int rs1, input int rs2);
        int n;
        n = 0;
        @(negedge clk);
        while (!dispatch_valid) begin
            n++;
            if (n > 50) timeout("dispatch_valid");
            @(negedge clk);
        end
        check("dispatch.fu", dispatch.fu, fu);
        check("dispatch.op", dispatch.op, op);
        check("dispatch.rs1", dispatch.rs1, rs1);
        check("dispatch.rs2", dispatch.rs2, rs2);
        @(posedge clk);
    endtask

    task automatic expect_wb(input int fu, input logic [4:0] rd);
        int n;
        n = 0;
        @(negedge clk);
        while (!wb_valid) begin
            n++;
            if (n > 50) timeout("wb_valid");
            @(negedge clk);
        end
        check("wb.fu", wb.fu, fu);
        check("wb.rd", wb.rd, rd);
        @(posedge clk);
        if (rd != 5'd0) pending[rd] = 1'b0;
    endtask

    task automatic complete(input logic [3:0] units);
        @(posedge clk);
        fu_done <= units;
        @(posedge clk);
        fu_done <= '0;
    endtask

    task automatic finish_test(input string name);
        $display("test %0d %s: %s (%0d errors)", tests_run + 1, name,
                 test_errors == 0 ? "ok" : "failed", test_errors);
        total_errors += test_errors;
        test_errors = 0;
        tests_run++;
    endtask

    initial begin
        logic [4:0] b;
        rst            = 1'b1;
        inst           = r_word(7'h01, 5'd2, 5'd1, 3'h0, 5'd3);
        issue_valid    = 1'b0;
        dispatch_ready = 1'b1;
        wb_ready       = 1'b1;
        fu_done        = '0;
        test_errors    = 0;
        total_errors   = 0;
        tests_run      = 0;
        rnd_state      = 32'ha423f4c9;
        for (int i = 0; i < 32; i++) pending[i] = 1'b0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        // Independent ADD, LW, MUL, DIV released together
        @(negedge clk);
        check("issue_ready", issue_ready, 1);
        check("dispatch_valid", dispatch_valid, 0);
        check("wb_valid", wb_valid, 0);
        rnd_state = xorshift(rnd_state);
        b = 5'd1 + 5'(rnd_state % 4);
        @(posedge clk);
        dispatch_ready <= 1'b0;
        issue_word(r_word(7'h00, b + 5'd8, b + 5'd4, 3'h0, b), b);
        issue_word(lw_word(b + 5'd12, b + 5'd16), b + 5'd12);
        issue_word(r_word(7'h01, b + 5'd8, b + 5'd4, 3'h0, b + 5'd20), b + 5'd20);
        issue_word(r_word(7'h01, b + 5'd8, b + 5'd16, 3'h4, b + 5'd24), b + 5'd24);
        repeat (3) begin
            @(negedge clk);
            check("dispatch_valid", dispatch_valid, 1);
            check("dispatch.fu", dispatch.fu, 0);
            check("dispatch.rs1", dispatch.rs1, b + 5'd4);
        end
        @(posedge clk);
        dispatch_ready <= 1'b1;
        expect_dispatch(0, 0, b + 5'd4, b + 5'd8);
        expect_dispatch(1, 4, b + 5'd16, 0);
        expect_dispatch(2, 0, b + 5'd4, b + 5'd8);
        expect_dispatch(3, 0, b + 5'd16, b + 5'd8);
        finish_test("decode and dispatch order");

        // Write-back held off on DIV while the other units complete
        @(posedge clk);
        wb_ready <= 1'b0;
        complete(4'b1000);
        complete(4'b0111);
        repeat (3) begin
            @(negedge clk);
            check("wb_valid", wb_valid, 1);
            check("wb.fu", wb.fu, 3);
            check("wb.rd", wb.rd, b + 5'd24);
        end
        @(posedge clk);
        wb_ready <= 1'b1;
        expect_wb(3, b + 5'd24);
        expect_wb(0, b);
        expect_wb(1, b + 5'd12);
        expect_wb(2, b + 5'd20);
        repeat (3) begin
            @(negedge clk);
            check("dispatch_valid", dispatch_valid, 0);
            check("wb_valid", wb_valid, 0);
        end

        // Held DIV dispatch stays put when the ALU becomes ready
        @(posedge clk);
        dispatch_ready <= 1'b0;
        issue_word(r_word(7'h01, 5'd2, 5'd1, 3'h5, 5'd9), 5'd9);
        issue_word(r_word(7'h00, 5'd4, 5'd3, 3'h0, 5'd11), 5'd11);
        repeat (3) begin
            @(negedge clk);
            check("dispatch_valid", dispatch_valid, 1);
            check("dispatch.fu", dispatch.fu, 3);
            check("dispatch.rs1", dispatch.rs1, 1);
        end
        @(posedge clk);
        dispatch_ready <= 1'b1;
        expect_dispatch(3, 1, 1, 2);
        expect_dispatch(0, 0, 3, 4);
        complete(4'b1001);
        expect_wb(0, 5'd11);
        expect_wb(3, 5'd9);
        finish_test("back-pressure");

        // Second MUL waits for the first one's write-back
        issue_word(r_word(7'h01, 5'd2, 5'd1, 3'h0, 5'd6), 5'd6);
        expect_dispatch(2, 0, 1, 2);
        @(posedge clk);
        inst        <= r_word(7'h01, 5'd4, 5'd3, 3'h1, 5'd7);
        issue_valid <= 1'b1;
        repeat (3) begin
            @(negedge clk);
            check("issue_ready", issue_ready, 0);
        end
        @(posedge clk);
        issue_valid <= 1'b0;
        complete(4'b0100);
        expect_wb(2, 5'd6);
        issue_word(r_word(7'h01, 5'd4, 5'd3, 3'h1, 5'd7), 5'd7);
        expect_dispatch(2, 1, 3, 4);
        complete(4'b0100);
        expect_wb(2, 5'd7);
        issue_word(32'hffffffff, 5'd0);
        repeat (3) begin
            @(negedge clk);
            check("dispatch_valid", dispatch_valid, 0);
        end
        finish_test("structural hazard and illegal word");

        // Same rd as a busy entry stalls while rd of x0 does not
        issue_word(r_word(7'h00, 5'd14, 5'd13, 3'h0, 5'd12), 5'd12);
        expect_dispatch(0, 0, 13, 14);
        @(posedge clk);
        inst        <= r_word(7'h01, 5'd16, 5'd15, 3'h0, 5'd12);
        issue_valid <= 1'b1;
        repeat (3) begin
            @(negedge clk);
            check("issue_ready", issue_ready, !pending[12]);
        end
        issue_word(r_word(7'h01, 5'd16, 5'd15, 3'h0, 5'd0), 5'd0);
        expect_dispatch(2, 0, 15, 16);
        complete(4'b0101);
        expect_wb(0, 5'd12);
        expect_wb(2, 5'd0);
        finish_test("WAW");

        // ADD reads the MUL result
        issue_word(r_word(7'h01, 5'd2, 5'd1, 3'h0, 5'd5), 5'd5);
        expect_dispatch(2, 0, 1, 2);
        issue_word(r_word(7'h00, 5'd3, 5'd5, 3'h0, 5'd7), 5'd7);
        repeat (3) begin
            @(negedge clk);
            check("dispatch_valid", dispatch_valid, !pending[5]);
        end
        complete(4'b0100);
        expect_wb(2, 5'd5);
        expect_dispatch(0, 0, 5, 3);
        complete(4'b0001);
        expect_wb(0, 5'd7);
        finish_test("RAW");

        // ALU write to x5 must wait for the DIV to read x5
        issue_word(r_word(7'h01, 5'd2, 5'd1, 3'h0, 5'd8), 5'd8);
        expect_dispatch(2, 0, 1, 2);
        issue_word(r_word(7'h01, 5'd5, 5'd8, 3'h4, 5'd10), 5'd10);
        issue_word(r_word(7'h00, 5'd4, 5'd3, 3'h0, 5'd5), 5'd5);
        expect_dispatch(0, 0, 3, 4);
        complete(4'b0001);
        repeat (3) begin
            @(negedge clk);
            check("wb_valid", wb_valid, 0);
        end
        complete(4'b0100);
        expect_wb(2, 5'd8);
        expect_dispatch(3, 0, 8, 5);
        expect_wb(0, 5'd5);
        complete(4'b1000);
        expect_wb(3, 5'd10);
        finish_test("WAR");

        $display("tests run: %0d, errors: %0d", tests_run, total_errors);
        if (total_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== scoreboard.f ====
rtl/scoreboard_pkg.sv
rtl/inst_decoder.sv
rtl/war_check.sv
rtl/fu_priority_select.sv
rtl/scoreboard_ctrl.sv
rtl/scoreboard_top.sv
verification/scoreboard_tb.sv

// ==== Makefile ====
SIM := obj_dir/scoreboard_sim

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -j 0 -f scoreboard.f --top-module scoreboard_tb \
		-o scoreboard_sim

run: compile
	./$(SIM) | tee sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
